/* design/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

  // datapath widths
  localparam int xlen = 64;
  localparam int if_to_id_width = 33;
  localparam int bj_ctrl_width = 66;

  // first fetch lands on reset_pc + 4
  localparam logic [xlen-1:0] reset_pc = 64'h7ffffffc;

  // instruction memory
  localparam logic [xlen-1:0] mem_base = 64'h80000000;
  localparam int mem_words = 256;
  localparam int mem_wait = 2;
  localparam int mem_idx_w = $clog2(mem_words);
  localparam int mem_cnt_w = $clog2(mem_wait + 1);

  // bus size and response codes
  localparam logic [1:0] size_w = 2'b10;
  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // fetch FSM states
  localparam logic [1:0] fetch_idle = 2'd0;
  localparam logic [1:0] fetch_addr = 2'd1;
  localparam logic [1:0] fetch_retn = 2'd2;

  // base opcodes
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;

  // decoded instruction kinds
  localparam logic [3:0] kind_alu_reg = 4'd0;
  localparam logic [3:0] kind_alu_imm = 4'd1;
  localparam logic [3:0] kind_load = 4'd2;
  localparam logic [3:0] kind_store = 4'd3;
  localparam logic [3:0] kind_branch = 4'd4;
  localparam logic [3:0] kind_jal = 4'd5;
  localparam logic [3:0] kind_jalr = 4'd6;
  localparam logic [3:0] kind_lui = 4'd7;
  localparam logic [3:0] kind_auipc = 4'd8;
  localparam logic [3:0] kind_illegal = 4'd9;
  localparam logic [3:0] kind_fetch_fault = 4'd10;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, six readings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

endpackage

`default_nettype wire

/* design/if_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module if_stage (
  input  logic                                    clk,
  input  logic                                    rst,

  output logic                                    if_to_id_valid,
  output logic [frontend_pkg::xlen-1:0]           if_to_id_pc,
  output logic [frontend_pkg::if_to_id_width-1:0] if_to_id_bus,
  input  logic                                    id_allowin,

  output logic                                    if_bj_ready,
  input  logic [frontend_pkg::bj_ctrl_width-1:0]  bj_ctrl_bus,

  output logic                                    mem_valid,
  output logic [frontend_pkg::xlen-1:0]           mem_addr,
  output logic [1:0]                              mem_size,
  input  logic                                    mem_ready,
  input  logic [31:0]                             mem_rdata,
  input  logic [1:0]                              mem_resp
);
  import frontend_pkg::*;

  logic [xlen-1:0] bj_pc;
  logic            bj_ena;
  logic            bj_valid;
  logic            bj_handshake;
  logic            mem_handshake;
  logic [1:0]      state;
  logic [1:0]      state_nxt;
  logic [xlen-1:0] next_pc;
  logic            ret_valid;
  logic            if_valid;
  logic            if_allowin;
  logic            if_load;
  logic [xlen-1:0] if_pc;
  logic [31:0]     if_inst;
  logic            if_fault;

  // token layout is target, enable, valid
  assign {bj_pc, bj_ena, bj_valid} = bj_ctrl_bus;

  // tokens are only taken between fetches
  assign if_bj_ready = state == fetch_idle;
  assign bj_handshake = if_bj_ready && bj_valid;
  assign next_pc = bj_ena ? bj_pc : if_pc + 64'd4;

  assign mem_valid = state == fetch_addr;
  assign mem_size = size_w;
  assign mem_handshake = mem_valid && mem_ready;

  // returned word waits in retn until the IF register is free
  assign ret_valid = state == fetch_retn;
  assign if_allowin = !if_valid || id_allowin;
  assign if_load = ret_valid && if_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      fetch_idle: begin
        if (bj_handshake) begin
          state_nxt = fetch_addr;
        end
      end
      fetch_addr: begin
        if (mem_handshake) begin
          state_nxt = fetch_retn;
        end
      end
      fetch_retn: begin
        if (if_load) begin
          state_nxt = fetch_idle;
        end
      end
      default: state_nxt = fetch_idle;
    endcase
  end

  // request address fixed at token time
  always_ff @(posedge clk) begin
    if (bj_handshake) begin
      mem_addr <= next_pc;
    end
  end

  // IF pipeline register
  always_ff @(posedge clk) begin
    if (rst) begin
      if_valid <= 1'b0;
    end else if (if_allowin) begin
      if_valid <= ret_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if_pc <= reset_pc;
    end else if (if_load) begin
      if_pc <= mem_addr;
    end
  end

  // memory holds rdata and resp until the next transfer
  always_ff @(posedge clk) begin
    if (if_load) begin
      if_inst <= mem_rdata;
      if_fault <= mem_resp != resp_okay;
    end
  end

  assign if_to_id_valid = if_valid;
  assign if_to_id_pc = if_pc;
  assign if_to_id_bus = {if_fault, if_inst};

  // request must not move while the memory is still waiting
  addr_hold_a: assert property (
    @(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
  ) else $error("if_stage: fetch address changed during a pending request");

endmodule

`default_nettype wire

/* design/inst_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module inst_mem (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               mem_valid,
  input  logic [frontend_pkg::xlen-1:0]      mem_addr,
  input  logic [1:0]                         mem_size,
  output logic                               mem_ready,
  output logic [31:0]                        mem_rdata,
  output logic [1:0]                         mem_resp,

  input  logic                               load_en,
  input  logic [frontend_pkg::mem_idx_w-1:0] load_addr,
  input  logic [31:0]                        load_data
);
  import frontend_pkg::*;

  logic [31:0]          mem [mem_words];
  logic [mem_cnt_w-1:0] wait_cnt;
  logic [xlen-1:0]      offset;
  logic                 in_range;
  logic [mem_idx_w-1:0] rd_idx;

  // byte offset from the base, wraps below it
  assign offset = mem_addr - mem_base;
  assign in_range = offset < 64'(mem_words * 4) && mem_addr[1:0] == 2'b00 &&
                    mem_size == size_w;
  assign rd_idx = offset[mem_idx_w+1:2];

  // load port, one word per cycle
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // ready comes up on the third cycle of valid, for one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
      mem_ready <= 1'b0;
    end else if (mem_valid && !mem_ready) begin
      if (wait_cnt == mem_cnt_w'(mem_wait - 1)) begin
        wait_cnt <= '0;
        mem_ready <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
        mem_ready <= 1'b0;
      end
    end else begin
      wait_cnt <= '0;
      mem_ready <= 1'b0;
    end
  end

  // response captured at the transfer edge
  always_ff @(posedge clk) begin
    if (mem_valid && mem_ready) begin
      if (in_range) begin
        mem_rdata <= mem[rd_idx];
        mem_resp <= resp_okay;
      end else begin
        mem_rdata <= '0;
        mem_resp <= resp_slverr;
      end
    end
  end

  // fetch holds valid up to the handshake
  ready_valid_a: assert property (
    @(posedge clk) disable iff (rst)
    mem_ready |-> mem_valid
  ) else $error("inst_mem: ready raised without a request");

endmodule

`default_nettype wire

/* design/id_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module id_stage (
  input  logic                                    clk,
  input  logic                                    rst,

  input  logic                                    if_to_id_valid,
  input  logic [frontend_pkg::xlen-1:0]           if_to_id_pc,
  input  logic [frontend_pkg::if_to_id_width-1:0] if_to_id_bus,
  output logic                                    id_allowin,

  output logic [frontend_pkg::bj_ctrl_width-1:0]  bj_ctrl_bus,
  input  logic                                    if_bj_ready,

  output logic                                    dec_valid,
  input  logic                                    dec_ready,
  output logic [frontend_pkg::xlen-1:0]           dec_pc,
  output logic [3:0]                              dec_kind,
  output logic [4:0]                              dec_rd,
  output logic [4:0]                              dec_rs1,
  output logic [4:0]                              dec_rs2,
  output logic [frontend_pkg::xlen-1:0]           dec_imm
);
  import frontend_pkg::*;

  inst_t           inst;
  logic            fault;
  logic            accept;
  logic            bj_transfer;
  logic            tok_pend;
  logic            tok_ena;
  logic [xlen-1:0] tok_pc;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [3:0]      kind_c;
  logic [4:0]      rd_c;
  logic [4:0]      rs1_c;
  logic [4:0]      rs2_c;
  logic [xlen-1:0] imm_c;

  assign inst = if_to_id_bus[31:0];
  assign fault = if_to_id_bus[if_to_id_width-1];

  // sign-extended immediates for each format
  assign imm_i = {{52{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{52{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{52{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                  inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {{32{inst.u_fmt.imm[19]}}, inst.u_fmt.imm, 12'b0};
  assign imm_j = {{44{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                  inst.j_fmt.imm_10_1, 1'b0};

  // fields absent from a format read as zero
  always_comb begin
    kind_c = kind_illegal;
    rd_c = '0;
    rs1_c = '0;
    rs2_c = '0;
    imm_c = '0;
    if (fault) begin
      kind_c = kind_fetch_fault;
    end else begin
      case (inst.r_fmt.opcode)
        op_reg: begin
          kind_c = kind_alu_reg;
          rd_c = inst.r_fmt.rd;
          rs1_c = inst.r_fmt.rs1;
          rs2_c = inst.r_fmt.rs2;
        end
        op_imm, op_load, op_jalr: begin
          if (inst.i_fmt.opcode == op_imm) begin
            kind_c = kind_alu_imm;
          end else if (inst.i_fmt.opcode == op_load) begin
            kind_c = kind_load;
          end else begin
            kind_c = kind_jalr;
          end
          rd_c = inst.i_fmt.rd;
          rs1_c = inst.i_fmt.rs1;
          imm_c = imm_i;
        end
        op_store: begin
          kind_c = kind_store;
          rs1_c = inst.s_fmt.rs1;
          rs2_c = inst.s_fmt.rs2;
          imm_c = imm_s;
        end
        op_branch: begin
          kind_c = kind_branch;
          rs1_c = inst.b_fmt.rs1;
          rs2_c = inst.b_fmt.rs2;
          imm_c = imm_b;
        end
        op_lui, op_auipc: begin
          kind_c = inst.u_fmt.opcode == op_lui ? kind_lui : kind_auipc;
          rd_c = inst.u_fmt.rd;
          imm_c = imm_u;
        end
        op_jal: begin
          kind_c = kind_jal;
          rd_c = inst.j_fmt.rd;
          imm_c = imm_j;
        end
        default: kind_c = kind_illegal;
      endcase
    end
  end

  assign id_allowin = !dec_valid || dec_ready;
  assign accept = if_to_id_valid && id_allowin;

  // decode output register
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (id_allowin) begin
      dec_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec_pc <= if_to_id_pc;
      dec_kind <= kind_c;
      dec_rd <= rd_c;
      dec_rs1 <= rs1_c;
      dec_rs2 <= rs2_c;
      dec_imm <= imm_c;
    end
  end

  // one token after reset, then one per accepted instruction
  assign bj_transfer = tok_pend && if_bj_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      tok_pend <= 1'b1;
      tok_ena <= 1'b0;
    end else if (accept) begin
      tok_pend <= 1'b1;
      tok_ena <= kind_c == kind_jal;
    end else if (bj_transfer) begin
      tok_pend <= 1'b0;
    end
  end

  // JAL target resolved here
  always_ff @(posedge clk) begin
    if (accept) begin
      tok_pc <= if_to_id_pc + imm_j;
    end
  end

  assign bj_ctrl_bus = {tok_pc, tok_ena, tok_pend};

  // held result must not change under back-pressure
  dec_hold_a: assert property (
    @(posedge clk) disable iff (rst)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_kind)
  ) else $error("id_stage: decoded output changed while stalled");

endmodule

`default_nettype wire

/* design/frontend_top.sv */
`default_nettype none
`timescale 1ns/1ps

module frontend_top (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               load_en,
  input  logic [frontend_pkg::mem_idx_w-1:0] load_addr,
  input  logic [31:0]                        load_data,

  input  logic                               dec_ready,
  output logic                               dec_valid,
  output logic [frontend_pkg::xlen-1:0]      dec_pc,
  output logic [3:0]                         dec_kind,
  output logic [4:0]                         dec_rd,
  output logic [4:0]                         dec_rs1,
  output logic [4:0]                         dec_rs2,
  output logic [frontend_pkg::xlen-1:0]      dec_imm
);
  import frontend_pkg::*;

  // fetch to memory
  logic                      mem_valid;
  logic                      mem_ready;
  logic [xlen-1:0]           mem_addr;
  logic [1:0]                mem_size;
  logic [31:0]               mem_rdata;
  logic [1:0]                mem_resp;

  // fetch to decode
  logic                      if_to_id_valid;
  logic [xlen-1:0]           if_to_id_pc;
  logic [if_to_id_width-1:0] if_to_id_bus;
  logic                      id_allowin;

  // decode back to fetch
  logic [bj_ctrl_width-1:0]  bj_ctrl_bus;
  logic                      if_bj_ready;

  if_stage u_if_stage (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_bus   (if_to_id_bus),
    .id_allowin     (id_allowin),
    .if_bj_ready    (if_bj_ready),
    .bj_ctrl_bus    (bj_ctrl_bus),
    .mem_valid      (mem_valid),
    .mem_addr       (mem_addr),
    .mem_size       (mem_size),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata),
    .mem_resp       (mem_resp)
  );

  inst_mem u_inst_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_size  (mem_size),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_resp  (mem_resp),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  id_stage u_id_stage (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_bus   (if_to_id_bus),
    .id_allowin     (id_allowin),
    .bj_ctrl_bus    (bj_ctrl_bus),
    .if_bj_ready    (if_bj_ready),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .dec_pc         (dec_pc),
    .dec_kind       (dec_kind),
    .dec_rd         (dec_rd),
    .dec_rs1        (dec_rs1),
    .dec_rs2        (dec_rs2),
    .dec_imm        (dec_imm)
  );

endmodule

`default_nettype wire

/* bench/frontend_tests.svh */
// unused words decode as illegal and carry their own index
task automatic clear_program();
  exp_pc.delete();
  exp_kind.delete();
  exp_rd.delete();
  exp_rs1.delete();
  exp_rs2.delete();
  exp_imm.delete();
  for (int i = 0; i < mem_words; i++) begin
    prog_mem[i] = {i[7:0], ~i[7:0], 9'h0, 7'h7f};
  end
endtask

task automatic expect_result(input logic [63:0] pc, input logic [3:0] kind,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [63:0] imm);
  exp_pc.push_back(pc);
  exp_kind.push_back(kind);
  exp_rd.push_back(rd);
  exp_rs1.push_back(rs1);
  exp_rs2.push_back(rs2);
  exp_imm.push_back(imm);
endtask

// imm is the full sign-extended value the decoder should report
task automatic add_instr(input int idx, input int fmt, input logic [6:0] op,
                         input logic [3:0] kind, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [63:0] imm);
  logic [4:0] rd_exp;
  logic [4:0] rs1_exp;
  logic [4:0] rs2_exp;
  prog_mem[idx] = encode(fmt, op, rd, rs1, rs2, 3'(idx), imm[31:0]);
  rd_exp = (fmt == fmt_s || fmt == fmt_b) ? 5'd0 : rd;
  rs1_exp = (fmt == fmt_u || fmt == fmt_j) ? 5'd0 : rs1;
  rs2_exp = (fmt == fmt_r || fmt == fmt_s || fmt == fmt_b) ? rs2 : 5'd0;
  expect_result(mem_base + 64'(4 * idx), kind, rd_exp, rs1_exp, rs2_exp, imm);
endtask

task automatic add_random(input int idx, input int fmt, input logic [6:0] op,
                          input logic [3:0] kind);
  logic [31:0] r;
  logic [31:0] f;
  logic [63:0] imm;
  r = next_random();
  f = next_random();
  case (fmt)
    fmt_i, fmt_s: imm = {{52{r[11]}}, r[11:0]};
    fmt_b: imm = {{51{r[12]}}, r[12:1], 1'b0};
    fmt_u: imm = {{32{r[31]}}, r[31:12], 12'b0};
    fmt_j: imm = {{43{r[20]}}, r[20:1], 1'b0};
    default: imm = '0;
  endcase
  add_instr(idx, fmt, op, kind, f[4:0], f[9:5], f[14:10], imm);
endtask

// memory is written while reset keeps fetch idle
task automatic load_and_reset();
  @(posedge clk);
  #1;
  rst = 1'b1;
  dec_ready = 1'b0;
  for (int i = 0; i < mem_words; i++) begin
    load_en = 1'b1;
    load_addr = mem_idx_w'(i);
    load_data = prog_mem[i];
    @(posedge clk);
    #1;
  end
  load_en = 1'b0;
  repeat (2) begin
    @(posedge clk);
    #1;
  end
  rst = 1'b0;
endtask

// a result transfers on the edge after valid and ready are seen together
task automatic collect_results(input string name, input int n, input bit bp);
  logic [31:0] r;
  int got;
  int idle;
  got = 0;
  idle = 0;
  while (got < n && idle < wait_limit) begin
    r = next_random();
    // ready mostly low so stalls outlast a whole fetch
    dec_ready = bp ? (r[18:16] == 3'd0) : 1'b1;
    if (dec_valid && dec_ready) begin
      check_value(name, "pc", exp_pc[got], dec_pc);
      check_value(name, "kind", 64'(exp_kind[got]), 64'(dec_kind));
      check_value(name, "rd", 64'(exp_rd[got]), 64'(dec_rd));
      check_value(name, "rs1", 64'(exp_rs1[got]), 64'(dec_rs1));
      check_value(name, "rs2", 64'(exp_rs2[got]), 64'(dec_rs2));
      check_value(name, "imm", exp_imm[got], dec_imm);
      got++;
      idle = 0;
    end else begin
      idle++;
    end
    @(posedge clk);
    #1;
  end
  dec_ready = 1'b0;
  if (got < n) begin
    $display("%s: timed out after %0d of %0d results", name, got, n);
    errors++;
  end
endtask

task automatic finish_test(input string name, input int err_start);
  tests++;
  $display("%s: %0d errors", name, errors - err_start);
endtask

task automatic reset_sequence_test();
  int e0;
  e0 = errors;
  clear_program();
  for (int i = 0; i < 4; i++) begin
    add_instr(i, fmt_i, op_imm, kind_alu_imm, 5'(i + 1), 5'd0, 5'd0, 64'(i));
  end
  load_and_reset();
  check_value("reset_sequence", "dec_valid", 64'd0, 64'(dec_valid));
  collect_results("reset_sequence", 4, 1'b0);
  finish_test("reset_sequence", e0);
endtask

task automatic decode_formats_test();
  int e0;
  e0 = errors;
  clear_program();
  add_random(0, fmt_r, op_reg, kind_alu_reg);
  add_random(1, fmt_i, op_imm, kind_alu_imm);
  add_random(2, fmt_i, op_load, kind_load);
  add_random(3, fmt_i, op_jalr, kind_jalr);
  add_random(4, fmt_s, op_store, kind_store);
  add_random(5, fmt_b, op_branch, kind_branch);
  add_random(6, fmt_u, op_lui, kind_lui);
  add_random(7, fmt_u, op_auipc, kind_auipc);
  // jal last, its target is random
  add_random(8, fmt_j, op_jal, kind_jal);
  load_and_reset();
  collect_results("decode_formats", 9, 1'b0);
  finish_test("decode_formats", e0);
endtask

task automatic backpressure_test();
  int e0;
  e0 = errors;
  load_and_reset();
  collect_results("backpressure", 9, 1'b1);
  finish_test("backpressure", e0);
endtask

// execution order 0, 4, 5, 2, 3, 9; words 1, 6, 7, 8 are skipped
task automatic jal_test();
  int e0;
  e0 = errors;
  clear_program();
  add_instr(0, fmt_j, op_jal, kind_jal, 5'd1, 5'd0, 5'd0, 64'd16);
  add_instr(4, fmt_i, op_imm, kind_alu_imm, 5'd2, 5'd2, 5'd0, 64'd4);
  add_instr(5, fmt_j, op_jal, kind_jal, 5'd0, 5'd0, 5'd0, -64'd12);
  add_instr(2, fmt_i, op_imm, kind_alu_imm, 5'd3, 5'd3, 5'd0, -64'd1);
  add_instr(3, fmt_j, op_jal, kind_jal, 5'd5, 5'd0, 5'd0, 64'd24);
  add_instr(9, fmt_i, op_imm, kind_alu_imm, 5'd4, 5'd4, 5'd0, 64'd9);
  load_and_reset();
  collect_results("jal", 6, 1'b0);
  finish_test("jal", e0);
endtask

task automatic fault_illegal_test();
  int e0;
  e0 = errors;
  clear_program();
  // custom-0 opcode is not decoded
  prog_mem[0] = encode(fmt_r, 7'b0001011, 5'd5, 5'd6, 5'd7, 3'd0, 32'd0);
  expect_result(mem_base, kind_illegal, 5'd0, 5'd0, 5'd0, 64'd0);
  // target lands one word past the end of memory
  add_instr(1, fmt_j, op_jal, kind_jal, 5'd1, 5'd0, 5'd0, 64'd1020);
  expect_result(mem_base + 64'(mem_words * 4), kind_fetch_fault, 5'd0, 5'd0, 5'd0, 64'd0);
  load_and_reset();
  collect_results("fault_illegal", 3, 1'b0);
  finish_test("fault_illegal", e0);
endtask

/* bench/frontend_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module frontend_tb;
  import frontend_pkg::*;

  // encoder formats
  localparam int fmt_r = 0;
  localparam int fmt_i = 1;
  localparam int fmt_s = 2;
  localparam int fmt_b = 3;
  localparam int fmt_u = 4;
  localparam int fmt_j = 5;
  localparam int wait_limit = 200;

  logic                 clk;
  logic                 rst;
  logic                 load_en;
  logic [mem_idx_w-1:0] load_addr;
  logic [31:0]          load_data;
  logic                 dec_ready;
  logic                 dec_valid;
  logic [xlen-1:0]      dec_pc;
  logic [3:0]           dec_kind;
  logic [4:0]           dec_rd;
  logic [4:0]           dec_rs1;
  logic [4:0]           dec_rs2;
  logic [xlen-1:0]      dec_imm;

  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          tests;

  // program image and expected results
  logic [31:0]     prog_mem [mem_words];
  logic [xlen-1:0] exp_pc[$];
  logic [3:0]      exp_kind[$];
  logic [4:0]      exp_rd[$];
  logic [4:0]      exp_rs1[$];
  logic [4:0]      exp_rs2[$];
  logic [xlen-1:0] exp_imm[$];

  frontend_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .dec_ready (dec_ready),
    .dec_valid (dec_valid),
    .dec_pc    (dec_pc),
    .dec_kind  (dec_kind),
    .dec_rd    (dec_rd),
    .dec_rs1   (dec_rs1),
    .dec_rs2   (dec_rs2),
    .dec_imm   (dec_imm)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // common fields first, then each format overwrites its immediate bits
  function automatic logic [31:0] encode(input int fmt, input logic [6:0] op,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [2:0] f3,
                                         input logic [31:0] imm);
    inst_t w;
    w = '0;
    w.r_fmt.opcode = op;
    w.r_fmt.rd = rd;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rs1 = rs1;
    w.r_fmt.rs2 = rs2;
    case (fmt)
      fmt_i: w.i_fmt.imm = imm[11:0];
      fmt_s: begin
        w.s_fmt.imm_hi = imm[11:5];
        w.s_fmt.imm_lo = imm[4:0];
      end
      fmt_b: begin
        w.b_fmt.imm_12 = imm[12];
        w.b_fmt.imm_11 = imm[11];
        w.b_fmt.imm_10_5 = imm[10:5];
        w.b_fmt.imm_4_1 = imm[4:1];
      end
      fmt_u: w.u_fmt.imm = imm[31:12];
      fmt_j: begin
        w.j_fmt.imm_20 = imm[20];
        w.j_fmt.imm_19_12 = imm[19:12];
        w.j_fmt.imm_11 = imm[11];
        w.j_fmt.imm_10_1 = imm[10:1];
      end
      default: w.r_fmt.funct7 = 7'd0;
    endcase
    return w;
  endfunction

  task automatic check_value(input string name, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERR %s %s: expected %h, actual %h", name, field, exp, act);
      errors++;
    end
  endtask

  `include "frontend_tests.svh"

  initial begin
    rst = 1'b1;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    dec_ready = 1'b0;
    lcg_state = 32'h6435_6b0b;
    errors = 0;
    checks = 0;
    tests = 0;
    repeat (2) @(posedge clk);
    #1;
    reset_sequence_test();
    decode_formats_test();
    // reuses the program and expectations of the formats test
    backpressure_test();
    jal_test();
    fault_illegal_test();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
design/frontend_pkg.sv
design/if_stage.sv
design/inst_mem.sv
design/id_stage.sv
design/frontend_top.sv
bench/frontend_tb.sv
